// ==== hdl/oled_macros.svh ====
//----------------------------------------
// constants for the oled frequency display
// column commands assume a 128 column panel
// font rom holds 8x16 glyphs, upper half first
//----------------------------------------
`ifndef OLED_MACROS_SVH
`define OLED_MACROS_SVH

//----------------------------------------
// link control bytes
//----------------------------------------
`define OLED_CTRL_CMD       8'h00
`define OLED_CTRL_DATA      8'h40

// command upper nibbles
`define OLED_PAGE_BASE      4'hB
`define OLED_COL_HI_BASE    4'h1
`define OLED_COL_LO_BASE    4'h0

// panel geometry
`define OLED_PAGES          8
`define OLED_COLUMNS        128

//----------------------------------------
// font and text line
//----------------------------------------
`define GLYPH_WIDTH         8
`define GLYPH_BYTES         16
`define TEXT_SLOTS          12
`define DIGIT_COUNT         5
`define ROM_ADDR_W          10

// glyph position to valid rom_data
`define ROM_WAIT            2

//----------------------------------------
// demo value range
//----------------------------------------
`define VALUE_RESET         43400
`define VALUE_WRAP_AT       45000
`define VALUE_WRAP_TO       44000
`define VALUE_W             16

`endif

// ==== hdl/oled_pkg.sv ====
//----------------------------------------
// types shared by the display blocks
// glyph codes 0 to 9 are digits, the rest
// follow the order of the font rom
//----------------------------------------
`include "oled_macros.svh"

package oled_pkg;

	typedef logic [7:0] oled_byte_t;
	typedef logic [3:0] digit_t;

	// index 0 is the units digit
	typedef digit_t [`DIGIT_COUNT-1:0] digit_vec_t;

	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [`VALUE_W-1:0] value_t;

	// font index
	typedef enum logic [4:0]
	{
		G_0 = 5'd0,
		G_1,
		G_2,
		G_3,
		G_4,
		G_5,
		G_6,
		G_7,
		G_8,
		G_9,
		G_F,
		G_R,
		G_E,
		G_Q,
		G_COLON,
		G_H,
		G_Z
	} glyph_e;

	typedef enum logic [7:0]
	{
		CTRL_CMD  = `OLED_CTRL_CMD,
		CTRL_DATA = `OLED_CTRL_DATA
	} ctrl_e;

	typedef enum logic [3:0]
	{
		ST_PAGE,
		ST_COL_HI,
		ST_COL_LO,
		ST_CLEAR,
		ST_GLYPH
	} layout_state_e;

endpackage

// ==== hdl/value_digits.sv ====
//----------------------------------------
// demo value source for the display
// steps every TICK_CYCLES clocks, wraps inside
// the macro range; digits update on sample only
//----------------------------------------
`include "oled_macros.svh"

module value_digits
	import oled_pkg::*;
#(
	parameter int TICK_CYCLES = 5_000_000
)
(
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       sample,
	output digit_vec_t digits
);

	localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	value_t            value;
	digit_vec_t        digit_now;

	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	// cycle divider
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// wrap value shows for one cycle
	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			value <= value_t'(`VALUE_RESET);
		else if (value == value_t'(`VALUE_WRAP_AT))
			value <= value_t'(`VALUE_WRAP_TO);
		else if (tick)
			value <= value + 1'b1;
	end

	//----------------------------------------
	// decimal split, one digit per register
	//----------------------------------------
	for (genvar k = 0; k < `DIGIT_COUNT; k++)
	begin : g_dec
		always_ff @(posedge CLOCK)
		begin
			digit_now[k] <= digit_t'((value / value_t'(10 ** k)) % value_t'(10));
		end
	end

	// snapshot held for a whole digit pass
	always_ff @(posedge CLOCK)
	begin
		if (sample)
			digits <= digit_now;
	end

endmodule

// ==== hdl/text_layout.sv ====
//----------------------------------------
// clears the panel once, writes the labels once,
// then refreshes the five digits forever
// link_req holds ctrl and byte until link_done
// start low only blocks new requests
//----------------------------------------
`include "oled_macros.svh"

module text_layout
	import oled_pkg::*;
(
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       start,
	input  logic       link_done,
	input  oled_byte_t rom_data,
	output logic       link_req,
	output ctrl_e      link_ctrl,
	output oled_byte_t link_byte,
	output glyph_e     glyph,
	output logic       half,
	output logic [2:0] col_idx,
	output logic       sample,
	output logic       frame_done
);

	// F r e q : sit before the digits, H z after
	localparam logic [3:0] FIRST_DIGIT_SLOT = 4'd5;
	localparam logic [3:0] LAST_DIGIT_SLOT  = 4'(FIRST_DIGIT_SLOT + `DIGIT_COUNT - 1);
	localparam logic [3:0] LAST_SLOT        = 4'(`TEXT_SLOTS - 1);
	localparam int         WAIT_W           = $clog2(`ROM_WAIT + 1);

	layout_state_e     state;
	logic              in_clear;
	logic [2:0]        clr_page;
	logic [3:0]        slot;
	logic [3:0]        next_slot;
	logic [3:0]        digit_pos;
	logic [6:0]        col_cnt;
	logic [WAIT_W-1:0] wait_cnt;
	logic [2:0]        page;
	logic [6:0]        column;
	ctrl_e             cur_ctrl;
	oled_byte_t        cur_byte;
	logic              ready;
	logic              launch;
	logic              accept;
	logic              glyph_last;

	assign col_idx    = col_cnt[2:0];
	assign launch     = !link_req && start && ready;
	assign accept     = link_req && link_done;
	assign glyph_last = (col_cnt[2:0] == 3'(`GLYPH_WIDTH - 1));

	// snapshot just before the first digit byte is fetched
	assign sample = accept && (state == ST_COL_LO) && !in_clear
		&& (slot == FIRST_DIGIT_SLOT) && !half;

	//----------------------------------------
	// slot to glyph
	//----------------------------------------
	always_comb
	begin
		digit_pos = LAST_DIGIT_SLOT - slot;
		case (slot)
			4'd0: glyph = G_F;
			4'd1: glyph = G_R;
			4'd2: glyph = G_E;
			4'd3: glyph = G_Q;
			4'd4: glyph = G_COLON;
			4'd10: glyph = G_H;
			4'd11: glyph = G_Z;
			// digit position, resolved by the addresser
			default: glyph = glyph_e'({1'b0, digit_pos});
		endcase
	end

	always_comb
	begin
		if (slot == FIRST_DIGIT_SLOT - 4'd1)
			next_slot = LAST_DIGIT_SLOT + 4'd1;
		else if (slot == LAST_DIGIT_SLOT || slot == LAST_SLOT)
			next_slot = FIRST_DIGIT_SLOT;
		else
			next_slot = slot + 4'd1;
	end

	//----------------------------------------
	// byte for the current step
	//----------------------------------------
	always_comb
	begin
		page     = in_clear ? clr_page : {2'b00, half};
		column   = in_clear ? 7'd0 : {slot, 3'b000};
		cur_ctrl = CTRL_CMD;
		cur_byte = '0;
		ready    = 1'b1;
		case (state)
			ST_PAGE: cur_byte = {`OLED_PAGE_BASE, 1'b0, page};
			ST_COL_HI: cur_byte = {`OLED_COL_HI_BASE, 1'b0, column[6:4]};
			ST_COL_LO: cur_byte = {`OLED_COL_LO_BASE, column[3:0]};
			ST_CLEAR: cur_ctrl = CTRL_DATA;
			ST_GLYPH:
			begin
				cur_ctrl = CTRL_DATA;
				cur_byte = rom_data;
				ready    = (wait_cnt == WAIT_W'(`ROM_WAIT));
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			state      <= ST_PAGE;
			in_clear   <= 1'b1;
			clr_page   <= '0;
			slot       <= '0;
			half       <= 1'b0;
			col_cnt    <= '0;
			wait_cnt   <= '0;
			link_req   <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			if (launch)
				link_req <= 1'b1;
			else if (!link_req && state == ST_GLYPH && !ready)
				wait_cnt <= wait_cnt + 1'b1;
			else if (accept)
			begin
				link_req <= 1'b0;
				case (state)
					ST_PAGE: state <= ST_COL_HI;
					ST_COL_HI: state <= ST_COL_LO;
					ST_COL_LO:
					begin
						col_cnt  <= '0;
						wait_cnt <= '0;
						state    <= in_clear ? ST_CLEAR : ST_GLYPH;
					end
					ST_CLEAR:
					begin
						if (col_cnt == 7'(`OLED_COLUMNS - 1))
						begin
							state    <= ST_PAGE;
							clr_page <= clr_page + 1'b1;
							if (clr_page == 3'(`OLED_PAGES - 1))
								in_clear <= 1'b0;
						end
						else
							col_cnt <= col_cnt + 1'b1;
					end
					ST_GLYPH:
					begin
						wait_cnt <= '0;
						if (glyph_last)
						begin
							state <= ST_PAGE;
							half  <= ~half;
							// lower half done, move to the next slot
							if (half)
							begin
								slot       <= next_slot;
								frame_done <= (slot == LAST_DIGIT_SLOT);
							end
						end
						else
							col_cnt <= col_cnt + 1'b1;
					end
					default: state <= ST_PAGE;
				endcase
			end
		end
	end

	// link payload, loaded as the request rises
	always_ff @(posedge CLOCK)
	begin
		if (launch)
		begin
			link_ctrl <= cur_ctrl;
			link_byte <= cur_byte;
		end
	end

endmodule

// ==== hdl/glyph_addresser.sv ====
//----------------------------------------
// font rom address for the current glyph byte
// digit positions take the snapshot digit
// address is registered, one cycle behind
//----------------------------------------
`include "oled_macros.svh"

module glyph_addresser
	import oled_pkg::*;
(
	input  logic       CLOCK,
	input  logic       RST_n,
	input  glyph_e     glyph,
	input  logic       half,
	input  logic [2:0] col_idx,
	input  digit_vec_t digits,
	output rom_addr_t  rom_addr
);

	digit_t    digit_val;
	logic [4:0] font_idx;
	rom_addr_t addr_next;

	always_comb
	begin
		digit_val = digits[glyph[2:0]];
		// codes below DIGIT_COUNT name a digit position
		if (5'(glyph) < 5'(`DIGIT_COUNT))
			font_idx = {1'b0, digit_val};
		else
			font_idx = 5'(glyph);
		addr_next = rom_addr_t'(font_idx) * rom_addr_t'(`GLYPH_BYTES)
			+ (half ? rom_addr_t'(`GLYPH_WIDTH) : rom_addr_t'(0))
			+ rom_addr_t'(col_idx);
	end

	always_ff @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
			rom_addr <= '0;
		else
			rom_addr <= addr_next;
	end

endmodule

// ==== hdl/freq_display.sv ====
//----------------------------------------
// oled frequency readout, "Freq:" digits "Hz"
// needs an external byte link and 8x16 font rom
// rom_data is expected one cycle after rom_addr
//----------------------------------------
module freq_display
	import oled_pkg::*;
#(
	parameter int TICK_CYCLES = 5_000_000
)
(
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       start,
	input  logic       link_done,
	input  oled_byte_t rom_data,
	output logic       link_req,
	output ctrl_e      link_ctrl,
	output oled_byte_t link_byte,
	output rom_addr_t  rom_addr,
	output logic       frame_done
);

	glyph_e     glyph;
	logic       half;
	logic [2:0] col_idx;
	logic       sample;
	digit_vec_t digits;

	value_digits #(
		.TICK_CYCLES (TICK_CYCLES)
	) u_value (
		.CLOCK  (CLOCK),
		.RST_n  (RST_n),
		.sample (sample),
		.digits (digits)
	);

	text_layout u_layout (
		.CLOCK      (CLOCK),
		.RST_n      (RST_n),
		.start      (start),
		.link_done  (link_done),
		.rom_data   (rom_data),
		.link_req   (link_req),
		.link_ctrl  (link_ctrl),
		.link_byte  (link_byte),
		.glyph      (glyph),
		.half       (half),
		.col_idx    (col_idx),
		.sample     (sample),
		.frame_done (frame_done)
	);

	glyph_addresser u_addr (
		.CLOCK    (CLOCK),
		.RST_n    (RST_n),
		.glyph    (glyph),
		.half     (half),
		.col_idx  (col_idx),
		.digits   (digits),
		.rom_addr (rom_addr)
	);

endmodule

// ==== verif/panel_model.sv ====
//----------------------------------------
// font rom, byte link responder and panel
// rom_data follows rom_addr by one cycle
// font is random, filled at the first edge
//----------------------------------------
`include "oled_macros.svh"

module panel_model
	import oled_pkg::*;
(
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       link_req,
	input  ctrl_e      link_ctrl,
	input  oled_byte_t link_byte,
	input  rom_addr_t  rom_addr,
	output logic       link_done,
	output oled_byte_t rom_data
);

	timeunit 1ns;
	timeprecision 1ps;

	oled_byte_t font [0:(1 << `ROM_ADDR_W) - 1];
	oled_byte_t panel [0:`OLED_PAGES-1][0:`OLED_COLUMNS-1];
	logic [2:0] page;
	logic [6:0] col;
	logic       busy;
	int         delay;
	int         pick;

	initial
	begin
		rom_data = '0;
		page     = '0;
		col      = '0;
		for (int p = 0; p < `OLED_PAGES; p++)
			for (int c = 0; c < `OLED_COLUMNS; c++)
				panel[p][c] = 8'hFF;
		@(posedge CLOCK);
		for (int a = 0; a < (1 << `ROM_ADDR_W); a++)
			font[a] = 8'($urandom);
	end

	always @(posedge CLOCK)
		rom_data <= font[rom_addr];

	//----------------------------------------
	// link responder with done after 1 to 6 cycles
	//----------------------------------------
	always @(posedge CLOCK or negedge RST_n)
	begin
		if (!RST_n)
		begin
			link_done <= 1'b0;
			busy      <= 1'b0;
			delay     <= 0;
		end
		else if (link_done)
		begin
			link_done <= 1'b0;
			busy      <= 1'b0;
		end
		else if (link_req && !busy)
		begin
			pick = $urandom_range(5, 0);
			busy <= 1'b1;
			if (pick == 0)
				link_done <= 1'b1;
			else
				delay <= pick - 1;
		end
		else if (busy)
		begin
			if (delay == 0)
				link_done <= 1'b1;
			else
				delay <= delay - 1;
		end
	end

	// panel side decode of commands and data
	always @(posedge CLOCK)
	begin
		if (RST_n && link_req && link_done)
		begin
			if (link_ctrl == CTRL_CMD)
			begin
				case (link_byte[7:4])
					`OLED_PAGE_BASE: page <= link_byte[2:0];
					`OLED_COL_HI_BASE: col[6:4] <= link_byte[2:0];
					`OLED_COL_LO_BASE: col[3:0] <= link_byte[3:0];
					default: ;
				endcase
			end
			else
			begin
				panel[page][col] <= link_byte;
				col              <= col + 1'b1;
			end
		end
	end

endmodule

// ==== verif/tb_freq_display.sv ====
//----------------------------------------
// random start gaps and link delays
// run ends after PASSES digit passes
//----------------------------------------
`include "oled_macros.svh"

module tb_freq_display
	import oled_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICK        = 300;
	localparam int PASSES      = 40;
	localparam int CLEAR_XFERS = `OLED_PAGES * (`OLED_COLUMNS + 3);
	localparam int SLOT_XFERS  = 2 * (3 + `GLYPH_WIDTH);
	localparam int LABEL_XFERS = 7 * SLOT_XFERS;
	localparam int PASS_XFERS  = `DIGIT_COUNT * SLOT_XFERS;
	localparam int WATCHDOG_NS = (PASSES * PASS_XFERS + CLEAR_XFERS + LABEL_XFERS + 8) * 12 * 4;

	logic       CLOCK = 1'b0;
	logic       RST_n;
	logic       start;
	logic       link_done;
	oled_byte_t rom_data;
	logic       link_req;
	ctrl_e      link_ctrl;
	oled_byte_t link_byte;
	rom_addr_t  rom_addr;
	logic       frame_done;

	int         value_errs = 0;
	int         proto_errs = 0;
	int         xfers = 0;
	int         xfers_at_frame = 0;
	int         passes = 0;
	int         low_left = 0;
	int         tick_cnt;
	int         last_num;
	value_t     val_cur;
	value_t     val_prev;
	digit_vec_t snap_exp;
	logic       prev_req;
	logic       prev_done;
	logic       prev_start;
	logic       prev_frame;
	ctrl_e      prev_ctrl;
	oled_byte_t prev_byte;

	int     label_slot [7] = '{0, 1, 2, 3, 4, 10, 11};
	glyph_e label_glyph [7] = '{G_F, G_R, G_E, G_Q, G_COLON, G_H, G_Z};

	freq_display #(
		.TICK_CYCLES (TICK)
	) uut (
		.CLOCK      (CLOCK),
		.RST_n      (RST_n),
		.start      (start),
		.link_done  (link_done),
		.rom_data   (rom_data),
		.link_req   (link_req),
		.link_ctrl  (link_ctrl),
		.link_byte  (link_byte),
		.rom_addr   (rom_addr),
		.frame_done (frame_done)
	);

	panel_model u_panel (
		.CLOCK     (CLOCK),
		.RST_n     (RST_n),
		.link_req  (link_req),
		.link_ctrl (link_ctrl),
		.link_byte (link_byte),
		.rom_addr  (rom_addr),
		.link_done (link_done),
		.rom_data  (rom_data)
	);

	always #2 CLOCK = ~CLOCK;

	//----------------------------------------
	// compare tasks
	//----------------------------------------
	task automatic check_byte(string what, oled_byte_t got, oled_byte_t exp);
		if (got !== exp)
		begin
			value_errs++;
			$display("[ERROR] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_ctrl(string what, ctrl_e got, ctrl_e exp);
		if (got !== exp)
		begin
			value_errs++;
			$display("[ERROR] %0t ns: %s is %02h, expected %s", $time, what, got, exp.name());
		end
	endtask

	task automatic check_digits(digit_vec_t got, digit_vec_t exp);
		if (got !== exp)
		begin
			value_errs++;
			$display("[ERROR] %0t ns: digits shown %05h, expected %05h", $time, got, exp);
		end
	endtask

	function automatic digit_vec_t split_decimal(value_t v);
		digit_vec_t d;
		int         rest;
		rest = v;
		for (int k = 0; k < `DIGIT_COUNT; k++)
		begin
			d[k] = digit_t'(rest % 10);
			rest = rest / 10;
		end
		return d;
	endfunction

	// digit whose font matches the panel at a slot, -1 if none
	function automatic int find_digit(int s);
		bit match;
		for (int d = 0; d < 10; d++)
		begin
			match = 1'b1;
			for (int i = 0; i < `GLYPH_BYTES; i++)
				if (u_panel.panel[i / 8][s * 8 + i % 8] !== u_panel.font[d * 16 + i])
					match = 1'b0;
			if (match)
				return d;
		end
		return -1;
	endfunction

	// expected command sequence per transfer
	task automatic check_transfer(int n);
		int m;
		int s;
		int r;
		m = n - CLEAR_XFERS;
		if (n < CLEAR_XFERS)
		begin
			s = 0;
			r = n % (`OLED_COLUMNS + 3);
		end
		else
		begin
			s = (m < LABEL_XFERS) ? label_slot[m / SLOT_XFERS]
				: 5 + ((m - LABEL_XFERS) % PASS_XFERS) / SLOT_XFERS;
			r = m % SLOT_XFERS;
		end
		if (r % 11 > 2 || (n < CLEAR_XFERS && r > 2))
		begin
			check_ctrl("data ctrl", link_ctrl, CTRL_DATA);
			if (n < CLEAR_XFERS)
				check_byte("clear byte", link_byte, 8'h00);
		end
		else
		begin
			check_ctrl("command ctrl", link_ctrl, CTRL_CMD);
			case (r % 11)
				0: check_byte("page command", link_byte,
					(n < CLEAR_XFERS) ? 8'hB0 | 8'(n / (`OLED_COLUMNS + 3)) : 8'hB0 | 8'(r / 11));
				1: check_byte("column high", link_byte, 8'h10 | 8'(s >> 1));
				default: check_byte("column low", link_byte, 8'((s & 1) << 3));
			endcase
		end
	endtask

	task automatic check_frame();
		digit_vec_t got;
		int         d;
		int         num;
		int         exp_xfers;
		exp_xfers = (passes == 0) ? CLEAR_XFERS + LABEL_XFERS + PASS_XFERS : PASS_XFERS;
		if (xfers - xfers_at_frame != exp_xfers)
		begin
			proto_errs++;
			$display("frame_done came after %0d transfers instead of %0d at %0t ns",
				xfers - xfers_at_frame, exp_xfers, $time);
		end
		xfers_at_frame = xfers;
		if (passes == 0)
		begin
			for (int p = 0; p < `OLED_PAGES; p++)
				for (int c = 0; c < `OLED_COLUMNS; c++)
					if (p > 1 || c >= `TEXT_SLOTS * 8)
						check_byte("cleared column", u_panel.panel[p][c], 8'h00);
			for (int g = 0; g < 7; g++)
				for (int i = 0; i < `GLYPH_BYTES; i++)
					check_byte("label byte", u_panel.panel[i / 8][label_slot[g] * 8 + i % 8],
						u_panel.font[int'(label_glyph[g]) * 16 + i]);
		end
		num = 0;
		got = '0;
		for (int s = 5; s < 10; s++)
		begin
			d = find_digit(s);
			if (d < 0)
			begin
				proto_errs++;
				$display("slot %0d shows no digit glyph at %0t ns", s, $time);
				d = 0;
			end
			got[9 - s] = digit_t'(d);
			num = num * 10 + d;
		end
		check_digits(got, snap_exp);
		if (num < `VALUE_RESET || num > `VALUE_WRAP_AT || (num < last_num && num < `VALUE_WRAP_TO))
		begin
			proto_errs++;
			$display("shown value %0d out of range or decreasing at %0t ns", num, $time);
		end
		last_num = num;
		passes++;
	endtask

	//----------------------------------------
	// monitor and value model
	//----------------------------------------
	always @(posedge CLOCK)
	begin
		if (!RST_n)
		begin
			tick_cnt   = 0;
			val_cur    = value_t'(`VALUE_RESET);
			val_prev   = value_t'(`VALUE_RESET);
			last_num   = `VALUE_RESET;
			prev_req   = 1'b0;
			prev_done  = 1'b0;
			prev_frame = 1'b0;
		end
		else
		begin
			if (prev_req && link_req && !prev_done)
			begin
				check_ctrl("held link_ctrl", link_ctrl, prev_ctrl);
				check_byte("held link_byte", link_byte, prev_byte);
			end
			if (link_req && !prev_req && !prev_start)
			begin
				proto_errs++;
				$display("request raised while start was low at %0t ns", $time);
			end
			if (link_req && link_done)
			begin
				check_transfer(xfers);
				// digits are sampled at the column low of the first digit slot
				if (xfers >= CLEAR_XFERS + LABEL_XFERS
					&& (xfers - CLEAR_XFERS - LABEL_XFERS) % PASS_XFERS == 2)
					snap_exp = split_decimal(val_prev);
				xfers++;
			end
			if (frame_done && prev_frame)
			begin
				proto_errs++;
				$display("frame_done held longer than one cycle at %0t ns", $time);
			end
			else if (frame_done)
				check_frame();
			val_prev = val_cur;
			if (val_cur == value_t'(`VALUE_WRAP_AT))
				val_cur = value_t'(`VALUE_WRAP_TO);
			else if (tick_cnt == TICK - 1)
				val_cur = val_cur + 1'b1;
			tick_cnt = (tick_cnt == TICK - 1) ? 0 : tick_cnt + 1;
		end
		prev_req   = link_req;
		prev_done  = link_done;
		prev_start = start;
		prev_frame = frame_done;
		prev_ctrl  = link_ctrl;
		prev_byte  = link_byte;
	end

	// start mostly high with short random gaps
	always @(posedge CLOCK)
	begin
		if (low_left > 0)
		begin
			start <= 1'b0;
			low_left--;
		end
		else if ($urandom_range(99, 0) < 2)
		begin
			low_left = $urandom_range(12, 1);
			start <= 1'b0;
		end
		else
			start <= 1'b1;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: only %0d of %0d digit passes finished", passes, PASSES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h235e_27ae));
		RST_n = 1'b0;
		start = 1'b0;
		repeat (8) @(posedge CLOCK);
		RST_n <= 1'b1;
		wait (passes == PASSES);
		@(posedge CLOCK);
		$display("passes %0d, transfers %0d, value errors %0d, protocol errors %0d",
			passes, xfers, value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/oled_pkg.sv
hdl/value_digits.sv
hdl/text_layout.sv
hdl/glyph_addresser.sv
hdl/freq_display.sv
verif/panel_model.sv
verif/tb_freq_display.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the frequency display testbench with Verilator and runs it.
# Pass or fail is taken from the simulation log.

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_freq_display

cd "$(dirname "$0")"

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing -Wno-fatal \
	-f list.f \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" \
	-o "sim_$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/sim_$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification passed" "$LOG_FILE"; then
	exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
